//--- verilog/xt_bus_pkg.sv
`default_nettype none

package xt_bus_pkg;

	// cpu side of the bus
	typedef logic [19:0] cpu_addr_t;
	typedef logic [7:0]  bus_data_t;

	// top bit set for ems space
	typedef logic [20:0] ram_addr_t;
	typedef logic [5:0]  ems_page_t;

	// external chip selects, active low
	typedef struct packed {
		logic dma;
		logic pic;
		logic pit;
		logic ppi;
		logic dma_page;
	} ext_cs_t;

	// internal register selects, active high
	typedef struct packed {
		logic ems;
		logic lpt;
		logic nmi_mask;
	} reg_sel_t;

	// strobes as seen on the bus, all active low
	typedef struct packed {
		logic io_read_n;
		logic io_write_n;
		logic memory_read_n;
		logic memory_write_n;
		logic address_enable_n;
	} bus_cmd_t;

	// read data from the pic, pit and ppi outside
	typedef struct packed {
		bus_data_t pic;
		bus_data_t pit;
		bus_data_t ppi;
	} ext_rdata_t;

	// i/o ports
	localparam logic [15:0] ems_io_base   = 16'h0260;
	localparam logic [15:0] nmi_mask_base = 16'h00a0;

	// ems page register write codes
	localparam bus_data_t ems_disable_code = 8'hff;
	localparam bus_data_t ems_keep_limit   = 8'h80;

	// read-back value of a disabled page
	localparam bus_data_t ems_no_page = 8'hff;

	// register reset values
	localparam bus_data_t nmi_mask_reset = 8'hff;
	localparam bus_data_t lpt_reset      = 8'hff;

endpackage

`default_nettype wire

//--- verilog/io_decoder.sv
`default_nettype none

module io_decoder #(
	parameter logic [15:0] lpt_base = 16'h0378
) (
	input  wire xt_bus_pkg::cpu_addr_t address_i,
	input  wire xt_bus_pkg::bus_cmd_t  bus_cmd_i,
	input  wire                        ems_enabled_i,
	input  wire                        tandy_mode_i,
	output xt_bus_pkg::ext_cs_t        ext_cs_o,
	output xt_bus_pkg::reg_sel_t       reg_sel_o
);

	import xt_bus_pkg::*;

	logic        io_request;
	logic [15:0] io_port;

	always_comb begin
		// i/o cycle with the cpu owning the bus
		io_request = ~bus_cmd_i.address_enable_n &
			(~bus_cmd_i.io_read_n | ~bus_cmd_i.io_write_n);
		io_port = address_i[15:0];

		ext_cs_o  = '1;
		reg_sel_o = '0;

		if (io_request) begin
			// motherboard devices sit below 0x100, 32 ports each
			if (io_port[9:8] == 2'b00) begin
				case (io_port[7:5])
					3'd0: begin
						ext_cs_o.dma = 1'b0;
					end
					3'd1: begin
						ext_cs_o.pic = 1'b0;
					end
					3'd2: begin
						ext_cs_o.pit = 1'b0;
					end
					3'd3: begin
						ext_cs_o.ppi = 1'b0;
					end
					3'd4: begin
						ext_cs_o.dma_page = 1'b0;
					end
					default: begin
						ext_cs_o = '1;
					end
				endcase
			end

			// four page registers at 0x260..0x263
			reg_sel_o.ems = ems_enabled_i &&
				({io_port[15:2], 2'b00} == ems_io_base);

			reg_sel_o.lpt = (io_port == lpt_base);

			// tandy only, eight ports mirrored
			reg_sel_o.nmi_mask = tandy_mode_i &&
				(io_port[15:3] == nmi_mask_base[15:3]);
		end
	end

endmodule

`default_nettype wire

//--- verilog/ems_mapper.sv
`default_nettype none

module ems_mapper (
	input  wire                         clock,
	input  wire                         reset,
	input  wire xt_bus_pkg::cpu_addr_t  address_i,
	input  wire xt_bus_pkg::bus_data_t  data_i,
	input  wire xt_bus_pkg::bus_cmd_t   bus_cmd_i,
	input  wire                         ems_sel_i,
	input  wire [1:0]                   ems_address_i,
	output xt_bus_pkg::ram_addr_t       ram_addr_o,
	output xt_bus_pkg::bus_data_t       ems_rdata_o
);

	import xt_bus_pkg::*;

	ems_page_t [3:0] ems_page;
	logic [3:0]      ems_enable;

	// write pipeline
	logic      write_pending;
	logic [1:0] write_index;
	bus_data_t write_data;

	// translation
	logic [3:0] window_base;
	logic [1:0] window_index;
	logic       in_window;
	logic       io_idle;
	logic [1:0] read_index;

	// stage 1: capture the port and byte
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			write_pending <= 1'b0;
		end else begin
			write_pending <= ems_sel_i & ~bus_cmd_i.io_write_n;
		end
	end

	always_ff @(posedge clock) begin
		write_index <= address_i[1:0];
		write_data  <= data_i;
	end

	// stage 2: apply the write rules
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ems_page   <= '0;
			ems_enable <= '0;
		end else if (write_pending) begin
			if (write_data == ems_disable_code) begin
				ems_enable[write_index] <= 1'b0;
			end else if (write_data < ems_keep_limit) begin
				ems_page[write_index]   <= write_data[5:0];
				ems_enable[write_index] <= 1'b1;
			end
			// 0x80..0xfe leave the page alone
		end
	end

	always_comb begin
		// 64k frame made of four 16k windows
		case (ems_address_i)
			2'd0: begin
				window_base = 4'ha;
			end
			2'd1: begin
				window_base = 4'hc;
			end
			default: begin
				window_base = 4'hd;
			end
		endcase

		io_idle      = bus_cmd_i.io_read_n & bus_cmd_i.io_write_n;
		window_index = address_i[15:14];
		in_window    = (address_i[19:16] == window_base);

		if (io_idle && in_window && ems_enable[window_index]) begin
			ram_addr_o = {1'b1, ems_page[window_index], address_i[13:0]};
		end else begin
			ram_addr_o = {1'b0, address_i};
		end
	end

	// read-back for the page on the low address bits
	assign read_index  = address_i[1:0];
	assign ems_rdata_o = ems_enable[read_index] ? {2'b00, ems_page[read_index]} : ems_no_page;

endmodule

`default_nettype wire

//--- verilog/port_registers.sv
`default_nettype none

module port_registers (
	input  wire                        clock,
	input  wire                        reset,
	input  wire xt_bus_pkg::bus_data_t data_i,
	input  wire                        io_write_n_i,
	input  wire                        lpt_sel_i,
	input  wire                        nmi_mask_sel_i,
	output xt_bus_pkg::bus_data_t      lpt_data_o,
	output xt_bus_pkg::bus_data_t      nmi_mask_o
);

	import xt_bus_pkg::*;

	logic lpt_write;
	logic nmi_mask_write;

	// selects already include the i/o request
	assign lpt_write      = lpt_sel_i & ~io_write_n_i;
	assign nmi_mask_write = nmi_mask_sel_i & ~io_write_n_i;

	// printer data latch
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data_o <= lpt_reset;
		end else if (lpt_write) begin
			lpt_data_o <= data_i;
		end
	end

	// tandy nmi mask, bits 3:1 also pick the ram bank outside
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			nmi_mask_o <= nmi_mask_reset;
		end else if (nmi_mask_write) begin
			nmi_mask_o <= data_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/readback_mux.sv
`default_nettype none

module readback_mux (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          io_read_n_i,
	input  wire                          interrupt_acknowledge_n_i,
	input  wire xt_bus_pkg::ext_cs_t     ext_cs_i,
	input  wire xt_bus_pkg::reg_sel_t    reg_sel_i,
	input  wire xt_bus_pkg::ext_rdata_t  ext_rdata_i,
	input  wire xt_bus_pkg::bus_data_t   ems_rdata_i,
	input  wire xt_bus_pkg::bus_data_t   nmi_mask_i,
	input  wire xt_bus_pkg::bus_data_t   lpt_data_i,
	output xt_bus_pkg::bus_data_t        data_bus_out_o,
	output logic                         data_bus_out_from_chipset_o
);

	logic io_read;

	assign io_read = ~io_read_n_i;

	// first match wins, inta ahead of everything
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_bus_out_from_chipset_o <= 1'b0;
			data_bus_out_o              <= '0;
		end else if (~interrupt_acknowledge_n_i) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= ext_rdata_i.pic;
		end else if (io_read && ~ext_cs_i.pic) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= ext_rdata_i.pic;
		end else if (io_read && ~ext_cs_i.pit) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= ext_rdata_i.pit;
		end else if (io_read && ~ext_cs_i.ppi) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= ext_rdata_i.ppi;
		end else if (io_read && reg_sel_i.ems) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= ems_rdata_i;
		end else if (io_read && reg_sel_i.nmi_mask) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= nmi_mask_i;
		end else if (io_read && reg_sel_i.lpt) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o              <= lpt_data_i;
		end else begin
			// nothing of ours, let the bus float
			data_bus_out_from_chipset_o <= 1'b0;
			data_bus_out_o              <= '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/xt_chipset.sv
`default_nettype none

module xt_chipset #(
	parameter logic [15:0] lpt_base = 16'h0378
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire xt_bus_pkg::cpu_addr_t   address_i,
	input  wire xt_bus_pkg::bus_data_t   data_i,
	input  wire xt_bus_pkg::bus_cmd_t    bus_cmd_i,
	input  wire                          interrupt_acknowledge_n_i,
	input  wire                          ems_enabled_i,
	input  wire [1:0]                    ems_address_i,
	input  wire                          tandy_mode_i,
	input  wire xt_bus_pkg::ext_rdata_t  ext_rdata_i,
	output wire xt_bus_pkg::ext_cs_t     ext_cs_o,
	output wire xt_bus_pkg::ram_addr_t   ram_addr_o,
	output wire xt_bus_pkg::bus_data_t   nmi_mask_o,
	output wire xt_bus_pkg::bus_data_t   data_bus_out_o,
	output wire                          data_bus_out_from_chipset_o
);

	import xt_bus_pkg::*;

	wire reg_sel_t  reg_sel;
	wire bus_data_t ems_rdata;
	wire bus_data_t lpt_data;

	io_decoder #(
		.lpt_base(lpt_base)
	) u_io_decoder (
		.address_i     (address_i),
		.bus_cmd_i     (bus_cmd_i),
		.ems_enabled_i (ems_enabled_i),
		.tandy_mode_i  (tandy_mode_i),
		.ext_cs_o      (ext_cs_o),
		.reg_sel_o     (reg_sel)
	);

	ems_mapper u_ems_mapper (
		.clock         (clock),
		.reset         (reset),
		.address_i     (address_i),
		.data_i        (data_i),
		.bus_cmd_i     (bus_cmd_i),
		.ems_sel_i     (reg_sel.ems),
		.ems_address_i (ems_address_i),
		.ram_addr_o    (ram_addr_o),
		.ems_rdata_o   (ems_rdata)
	);

	port_registers u_port_registers (
		.clock          (clock),
		.reset          (reset),
		.data_i         (data_i),
		.io_write_n_i   (bus_cmd_i.io_write_n),
		.lpt_sel_i      (reg_sel.lpt),
		.nmi_mask_sel_i (reg_sel.nmi_mask),
		.lpt_data_o     (lpt_data),
		.nmi_mask_o     (nmi_mask_o)
	);

	readback_mux u_readback_mux (
		.clock                       (clock),
		.reset                       (reset),
		.io_read_n_i                 (bus_cmd_i.io_read_n),
		.interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
		.ext_cs_i                    (ext_cs_o),
		.reg_sel_i                   (reg_sel),
		.ext_rdata_i                 (ext_rdata_i),
		.ems_rdata_i                 (ems_rdata),
		.nmi_mask_i                  (nmi_mask_o),
		.lpt_data_i                  (lpt_data),
		.data_bus_out_o              (data_bus_out_o),
		.data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
	);

endmodule

`default_nettype wire

//--- tb/xt_bus_tasks.svh
`ifndef XT_BUS_TASKS_SVH
`define XT_BUS_TASKS_SVH

// galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ 32'h8020_0003;
	end
	return next;
endfunction

// one lfsr step per bit taken
task automatic take_bits(input int count, output logic [31:0] value);
	int i;
	value = '0;
	for (i = 0; i < count; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
endtask

// arms the read-back check one cycle after the strobe, then releases
task automatic hold_for_answer(input logic flag, input bus_data_t data);
	@(posedge clock);
	exp_flag   <= flag;
	exp_data   <= data;
	read_check <= 1'b1;
	repeat (2) @(posedge clock);
	bus_cmd_i                 <= cmd_idle;
	interrupt_acknowledge_n_i <= 1'b1;
	cs_check                  <= 1'b0;
	@(posedge clock);
	read_check <= 1'b0;
endtask

task automatic io_read(input cpu_addr_t addr, input logic flag, input bus_data_t data);
	@(posedge clock);
	address_i <= addr;
	bus_cmd_i <= cmd_io_read;
	exp_cs    <= expected_cs(addr);
	cs_check  <= 1'b1;
	hold_for_answer(flag, data);
endtask

task automatic io_write(input cpu_addr_t addr, input bus_data_t data);
	@(posedge clock);
	address_i <= addr;
	data_i    <= data;
	bus_cmd_i <= cmd_io_write;
	exp_cs    <= expected_cs(addr);
	cs_check  <= 1'b1;
	repeat (3) @(posedge clock);
	bus_cmd_i <= cmd_idle;
	cs_check  <= 1'b0;
endtask

task automatic interrupt_acknowledge(input bus_data_t vector);
	@(posedge clock);
	interrupt_acknowledge_n_i <= 1'b0;
	hold_for_answer(1'b1, vector);
endtask

task automatic mem_access(input cpu_addr_t addr, input logic is_write);
	@(posedge clock);
	address_i <= addr;
	bus_cmd_i <= is_write ? cmd_mem_write : cmd_mem_read;
	exp_ram   <= expected_ram(addr, ems_address_i);
	ram_check <= 1'b1;
	repeat (3) @(posedge clock);
	bus_cmd_i <= cmd_idle;
	ram_check <= 1'b0;
endtask

// bus idle, nothing may come back
task automatic expect_quiet(input int cycles);
	@(posedge clock);
	exp_flag   <= 1'b0;
	exp_data   <= '0;
	read_check <= 1'b1;
	repeat (cycles) @(posedge clock);
	read_check <= 1'b0;
endtask

`endif

//--- tb/tb_xt_chipset.sv
`default_nettype none

module tb_xt_chipset;

	timeunit 1ns;
	timeprecision 100ps;

	import xt_bus_pkg::*;

	localparam logic [15:0] lpt_port = 16'h0378;
	localparam int cycle_limit = 4000;

	localparam bus_cmd_t cmd_idle = '{io_read_n: 1'b1, io_write_n: 1'b1,
		memory_read_n: 1'b1, memory_write_n: 1'b1, address_enable_n: 1'b0};
	localparam bus_cmd_t cmd_io_read = '{io_read_n: 1'b0, io_write_n: 1'b1,
		memory_read_n: 1'b1, memory_write_n: 1'b1, address_enable_n: 1'b0};
	localparam bus_cmd_t cmd_io_write = '{io_read_n: 1'b1, io_write_n: 1'b0,
		memory_read_n: 1'b1, memory_write_n: 1'b1, address_enable_n: 1'b0};
	localparam bus_cmd_t cmd_mem_read = '{io_read_n: 1'b1, io_write_n: 1'b1,
		memory_read_n: 1'b0, memory_write_n: 1'b1, address_enable_n: 1'b0};
	localparam bus_cmd_t cmd_mem_write = '{io_read_n: 1'b1, io_write_n: 1'b1,
		memory_read_n: 1'b1, memory_write_n: 1'b0, address_enable_n: 1'b0};

	logic       clock;
	logic       reset;
	cpu_addr_t  address_i;
	bus_data_t  data_i;
	bus_cmd_t   bus_cmd_i;
	logic       interrupt_acknowledge_n_i;
	logic       ems_enabled_i;
	logic [1:0] ems_address_i;
	logic       tandy_mode_i;
	ext_rdata_t ext_rdata_i;
	ext_cs_t    ext_cs_o;
	ram_addr_t  ram_addr_o;
	bus_data_t  nmi_mask_o;
	bus_data_t  data_bus_out_o;
	logic       data_bus_out_from_chipset_o;

	// expectations armed by the bus tasks
	logic      cs_check;
	logic      read_check;
	logic      ram_check;
	ext_cs_t   exp_cs;
	logic      exp_flag;
	bus_data_t exp_data;
	ram_addr_t exp_ram;
	bus_data_t exp_nmi;

	// ems page register model
	ems_page_t  model_page [4];
	logic [3:0] model_en;
	ext_rdata_t ext_model;

	logic [31:0] lfsr_state;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	int cycle_count = 0;

	xt_chipset #(
		.lpt_base(lpt_port)
	) DUT (
		.clock                       (clock),
		.reset                       (reset),
		.address_i                   (address_i),
		.data_i                      (data_i),
		.bus_cmd_i                   (bus_cmd_i),
		.interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
		.ems_enabled_i               (ems_enabled_i),
		.ems_address_i               (ems_address_i),
		.tandy_mode_i                (tandy_mode_i),
		.ext_rdata_i                 (ext_rdata_i),
		.ext_cs_o                    (ext_cs_o),
		.ram_addr_o                  (ram_addr_o),
		.nmi_mask_o                  (nmi_mask_o),
		.data_bus_out_o              (data_bus_out_o),
		.data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
	);

	// one select per 32-port block below 0xa0
	function automatic ext_cs_t expected_cs(input cpu_addr_t addr);
		ext_cs_t cs;
		cs = '1;
		if (addr[9:8] == 2'b00) begin
			case (addr[7:5])
				3'd0: cs.dma = 1'b0;
				3'd1: cs.pic = 1'b0;
				3'd2: cs.pit = 1'b0;
				3'd3: cs.ppi = 1'b0;
				3'd4: cs.dma_page = 1'b0;
				default: cs = '1;
			endcase
		end
		return cs;
	endfunction

	function automatic logic [3:0] window_frame(input logic [1:0] sel);
		if (sel == 2'd0) begin
			return 4'ha;
		end
		return (sel == 2'd1) ? 4'hc : 4'hd;
	endfunction

	function automatic ram_addr_t expected_ram(input cpu_addr_t addr, input logic [1:0] sel);
		logic [1:0] k;
		k = addr[15:14];
		if (addr[19:16] == window_frame(sel) && model_en[k]) begin
			return {1'b1, model_page[k], addr[13:0]};
		end
		return {1'b0, addr};
	endfunction

	function automatic bus_data_t ems_readback(input logic [1:0] n);
		return model_en[n] ? {2'b00, model_page[n]} : 8'hff;
	endfunction

	`include "xt_bus_tasks.svh"

	task automatic ems_write(input logic [1:0] n, input bus_data_t b);
		io_write(20'h00260 + n, b);
		if (b == 8'hff) begin
			model_en[n] = 1'b0;
		end else if (b < 8'h80) begin
			model_page[n] = b[5:0];
			model_en[n]   = 1'b1;
		end
	endtask

	task automatic ems_read_all();
		int n;
		for (n = 0; n < 4; n++) begin
			io_read(20'h00260 + n[1:0], 1'b1, ems_readback(n[1:0]));
		end
	endtask

	task automatic load_ext_rdata();
		logic [31:0] r;
		take_bits(24, r);
		ext_model = r[23:0];
		@(posedge clock);
		ext_rdata_i <= ext_model;
	endtask

	task automatic end_test(input string name);
		int new_errors;
		@(posedge clock);
		new_errors = error_count - test_start_errors;
		tests_run++;
		if (new_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, new_errors);
		end
		test_start_errors = error_count;
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: test sequence still running after %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	cs_match: assert property (@(posedge clock) disable iff (reset)
		cs_check |-> ext_cs_o == exp_cs)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: ext_cs_o is %b, expected %b",
			$time, $sampled(ext_cs_o), $sampled(exp_cs));
	end

	cs_idle: assert property (@(posedge clock) disable iff (reset)
		bus_cmd_i.io_read_n && bus_cmd_i.io_write_n |-> &ext_cs_o)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: ext_cs_o is %b, expected 11111",
			$time, $sampled(ext_cs_o));
	end

	flag_match: assert property (@(posedge clock) disable iff (reset)
		read_check |-> data_bus_out_from_chipset_o == exp_flag)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: data_bus_out_from_chipset_o is %b, expected %b",
			$time, $sampled(data_bus_out_from_chipset_o), $sampled(exp_flag));
	end

	data_match: assert property (@(posedge clock) disable iff (reset)
		read_check |-> data_bus_out_o == exp_data)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: data_bus_out_o is %h, expected %h",
			$time, $sampled(data_bus_out_o), $sampled(exp_data));
	end

	ram_match: assert property (@(posedge clock) disable iff (reset)
		ram_check |-> ram_addr_o == exp_ram)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: ram_addr_o is %h, expected %h",
			$time, $sampled(ram_addr_o), $sampled(exp_ram));
	end

	// mask only settles once the write strobe is gone
	nmi_match: assert property (@(posedge clock) disable iff (reset)
		bus_cmd_i.io_read_n && bus_cmd_i.io_write_n |-> nmi_mask_o == exp_nmi)
	else begin
		error_count = error_count + 1;
		$display("** Error at %0t: nmi_mask_o is %h, expected %h",
			$time, $sampled(nmi_mask_o), $sampled(exp_nmi));
	end

	initial begin
		logic [31:0] r;
		cpu_addr_t   addr;
		bus_data_t   b;
		int          sel;
		int          k;
		int          round;

		lfsr_state = 32'h6bcb_7f85;
		reset = 1'b1;
		address_i = '0;
		data_i = '0;
		bus_cmd_i = cmd_idle;
		interrupt_acknowledge_n_i = 1'b1;
		ems_enabled_i = 1'b1;
		ems_address_i = 2'd0;
		tandy_mode_i = 1'b0;
		ext_rdata_i = '0;
		ext_model = '0;
		cs_check = 1'b0;
		read_check = 1'b0;
		ram_check = 1'b0;
		exp_cs = '1;
		exp_flag = 1'b0;
		exp_data = '0;
		exp_ram = '0;
		exp_nmi = 8'hff;
		model_en = '0;
		for (k = 0; k < 4; k++) begin
			model_page[k] = '0;
		end

		repeat (5) @(posedge clock);
		reset <= 1'b0;

		expect_quiet(3);
		end_test("reset state");

		load_ext_rdata();
		io_read(20'h00000, 1'b0, 8'h00);
		io_read(20'h00020, 1'b1, ext_model.pic);
		io_read(20'h00040, 1'b1, ext_model.pit);
		io_read(20'h00060, 1'b1, ext_model.ppi);
		io_read(20'h00080, 1'b0, 8'h00);
		io_write(20'h00081, 8'h5a);
		mem_access(20'h00020, 1'b0);
		mem_access(20'h00060, 1'b1);
		end_test("external chip selects");

		// one byte of each kind, then random
		ems_write(2'd0, 8'h2a);
		ems_write(2'd1, 8'h85);
		ems_write(2'd2, 8'h3f);
		ems_write(2'd3, 8'hff);
		ems_read_all();
		for (round = 0; round < 5; round++) begin
			for (k = 0; k < 4; k++) begin
				take_bits(8, r);
				ems_write(k[1:0], r[7:0]);
			end
			ems_read_all();
		end
		end_test("ems registers");

		ems_write(2'd0, 8'h11);
		ems_write(2'd3, 8'hff);
		for (sel = 0; sel < 3; sel++) begin
			@(posedge clock);
			ems_address_i <= sel[1:0];
			for (k = 0; k < 4; k++) begin
				take_bits(14, r);
				addr = {window_frame(sel[1:0]), k[1:0], r[13:0]};
				mem_access(addr, k[0]);
			end
			take_bits(16, r);
			mem_access({window_frame(sel[1:0]) ^ 4'h1, r[15:0]}, 1'b0);
		end
		// page registers are off the bus while ems is disabled
		@(posedge clock);
		ems_enabled_i <= 1'b0;
		io_write(20'h00260, 8'h15);
		io_read(20'h00260, 1'b0, 8'h00);
		@(posedge clock);
		ems_enabled_i <= 1'b1;
		io_read(20'h00260, 1'b1, ems_readback(2'd0));
		end_test("ems translation");

		io_read({4'h0, lpt_port}, 1'b1, 8'hff);
		take_bits(8, r);
		io_write({4'h0, lpt_port}, r[7:0]);
		io_read({4'h0, lpt_port}, 1'b1, r[7:0]);
		take_bits(8, r);
		b = r[7:0];
		io_write(20'h000a0, b);
		io_read(20'h000a0, 1'b0, 8'h00);
		@(posedge clock);
		tandy_mode_i <= 1'b1;
		io_write(20'h000a0, b);
		exp_nmi = b;
		io_read(20'h000a0, 1'b1, b);
		@(posedge clock);
		tandy_mode_i <= 1'b0;
		io_read(20'h000a0, 1'b0, 8'h00);
		end_test("printer latch and nmi mask");

		load_ext_rdata();
		interrupt_acknowledge(ext_model.pic);
		io_read(20'h00041, 1'b1, ext_model.pit);
		io_read(20'h00062, 1'b1, ext_model.ppi);
		io_read(20'h000c0, 1'b0, 8'h00);
		io_read(20'h003f0, 1'b0, 8'h00);
		end_test("read-back priority");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- xt_chipset.f
+incdir+tb
verilog/xt_bus_pkg.sv
verilog/io_decoder.sv
verilog/ems_mapper.sv
verilog/port_registers.sv
verilog/readback_mux.sv
verilog/xt_chipset.sv
tb/tb_xt_chipset.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the xt_chipset testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--timescale 1ns/100ps \
	--top-module tb_xt_chipset \
	--Mdir obj_dir \
	-o sim_xt_chipset \
	-f xt_chipset.f

./obj_dir/sim_xt_chipset | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
